/* rt_pkg.sv */
package rt_pkg;

  typedef logic signed [31:0] coord_t;  // Whole units or FRAC_BITS distances
  typedef logic [11:0] node_addr_t;
  typedef logic [13:0] trig_addr_t;
  typedef logic [7:0] num_trigs_t;      // Zero marks an inner child

  localparam int FRAC_BITS = 16;

  // A link names the next pair for an inner child and the first triangle for a leaf
  typedef union packed {
    struct packed {
      logic [1:0] pad;
      node_addr_t addr;
    } node;
    trig_addr_t trig;
  } child_link_u;

  localparam int WORDS_PER_CHILD = 8;
  localparam int WORDS_PER_PAIR = 16;

  // Word offsets within one child record
  localparam int W_X_MIN = 0;
  localparam int W_X_MAX = 1;
  localparam int W_Y_MIN = 2;
  localparam int W_Y_MAX = 3;
  localparam int W_Z_MIN = 4;
  localparam int W_Z_MAX = 5;
  localparam int W_NUM_TRIGS = 6;
  localparam int W_LINK = 7;

  localparam int SLAB_LATENCY = 4;

endpackage

/* node_memory.sv */
`timescale 1ns/1ps

module node_memory
  import rt_pkg::*;
#(
  parameter int NODE_WORDS = 4096
) (
  input  logic        clk,
  input  logic        mem_we,
  input  node_addr_t  mem_wr_addr,
  input  logic [31:0] mem_wdata,
  input  node_addr_t  mem_rd_addr,
  output logic [31:0] mem_rdata
);

  logic [31:0] words [NODE_WORDS];

  always_ff @(posedge clk) begin
    if (mem_we) begin
      words[mem_wr_addr] <= mem_wdata;
    end
    mem_rdata <= words[mem_rd_addr];  // One cycle read latency
  end

  // Loader must stay inside the configured depth
  a_wr_in_range: assert property (@(posedge clk)
    mem_we |-> int'(mem_wr_addr) < NODE_WORDS);

endmodule

/* node_fetch.sv */
`timescale 1ns/1ps

module node_fetch
  import rt_pkg::*;
(
  input  logic        clk,
  input  logic        counter_reg_reset,
  input  logic        fetch_start,
  input  node_addr_t  fetch_addr,
  output node_addr_t  mem_rd_addr,
  input  logic [31:0] mem_rdata,
  output logic        pair_valid,
  output coord_t      l_bounds [6],
  output coord_t      r_bounds [6],
  output num_trigs_t  l_num_trigs,
  output num_trigs_t  r_num_trigs,
  output child_link_u l_link,
  output child_link_u r_link
);

  localparam logic [3:0] LAST_WORD = 4'(WORDS_PER_PAIR - 1);

  node_addr_t base_addr;
  logic [3:0] word_cnt;   // Word currently on mem_rdata
  logic       busy;
  logic [2:0] word_off;
  logic       right_word;

  assign word_off   = 3'(word_cnt % WORDS_PER_CHILD);
  assign right_word = word_cnt >= 4'(WORDS_PER_CHILD);

  // Address runs one word ahead of the capture
  assign mem_rd_addr = fetch_start ? fetch_addr
                                   : base_addr + node_addr_t'(word_cnt) + 12'd1;

  always_ff @(posedge clk) begin
    if (counter_reg_reset) begin
      busy       <= 1'b0;
      word_cnt   <= '0;
      pair_valid <= 1'b0;
    end else begin
      pair_valid <= 1'b0;
      if (fetch_start) begin
        busy     <= 1'b1;
        word_cnt <= '0;
      end else if (busy) begin
        word_cnt <= word_cnt + 4'd1;
        if (word_cnt == LAST_WORD) begin
          busy       <= 1'b0;
          pair_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_start) begin
      base_addr <= fetch_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (busy) begin
      if (word_off == 3'(W_NUM_TRIGS)) begin
        if (right_word) r_num_trigs <= mem_rdata[7:0];
        else l_num_trigs <= mem_rdata[7:0];
      end else if (word_off == 3'(W_LINK)) begin
        if (right_word) r_link <= mem_rdata[13:0];
        else l_link <= mem_rdata[13:0];
      end else if (right_word) begin
        r_bounds[word_off] <= mem_rdata;
      end else begin
        l_bounds[word_off] <= mem_rdata;
      end
    end
  end

  a_no_restart: assert property (@(posedge clk) disable iff (counter_reg_reset)
    busy |-> !fetch_start);

endmodule

/* slab_test.sv */
`timescale 1ns/1ps

module slab_test
  import rt_pkg::*;
(
  input  logic   clk,
  input  logic   counter_reg_reset,
  input  logic   slab_start,
  input  coord_t origin_x,
  input  coord_t origin_y,
  input  coord_t origin_z,
  input  coord_t inv_dir_x,
  input  coord_t inv_dir_y,
  input  coord_t inv_dir_z,
  input  coord_t tmax,
  input  coord_t l_bounds [6],
  input  coord_t r_bounds [6],
  output logic   slab_valid,
  output logic   l_hit,
  output logic   r_hit,
  output logic   l_first,
  output coord_t l_entry,
  output coord_t r_entry
);

  localparam int MIN_OFF [3] = '{W_X_MIN, W_Y_MIN, W_Z_MIN};
  localparam int MAX_OFF [3] = '{W_X_MAX, W_Y_MAX, W_Z_MAX};

  logic [SLAB_LATENCY-1:0] vld;
  coord_t org [3];
  coord_t inv [3];
  coord_t lo1 [6];      // Index is child * 3 + axis
  coord_t hi1 [6];
  coord_t lo2 [6];
  coord_t hi2 [6];
  coord_t near3 [6];
  coord_t far3 [6];
  coord_t entry4 [2];
  coord_t exit4 [2];

  function automatic coord_t slab_dist(input coord_t delta, input coord_t inv_d);
    logic signed [63:0] prod;
    prod = delta * inv_d;
    return coord_t'(prod >>> FRAC_BITS);
  endfunction

  assign org[0] = origin_x;
  assign org[1] = origin_y;
  assign org[2] = origin_z;
  assign inv[0] = inv_dir_x;
  assign inv[1] = inv_dir_y;
  assign inv[2] = inv_dir_z;

  always_ff @(posedge clk) begin
    if (counter_reg_reset) vld <= '0;
    else vld <= {vld[SLAB_LATENCY-2:0], slab_start};
  end

  assign slab_valid = vld[SLAB_LATENCY-1];

  always_ff @(posedge clk) begin
    if (slab_start) begin
      for (int a = 0; a < 3; a++) begin
        lo1[a]     <= l_bounds[MIN_OFF[a]] - org[a];
        hi1[a]     <= l_bounds[MAX_OFF[a]] - org[a];
        lo1[a + 3] <= r_bounds[MIN_OFF[a]] - org[a];
        hi1[a + 3] <= r_bounds[MAX_OFF[a]] - org[a];
      end
    end
    if (vld[0]) begin
      for (int j = 0; j < 6; j++) begin
        lo2[j] <= slab_dist(lo1[j], inv[j % 3]);
        hi2[j] <= slab_dist(hi1[j], inv[j % 3]);
      end
    end
    if (vld[1]) begin
      for (int j = 0; j < 6; j++) begin
        near3[j] <= inv[j % 3][31] ? hi2[j] : lo2[j];  // Negative direction swaps the slab
        far3[j]  <= inv[j % 3][31] ? lo2[j] : hi2[j];
      end
    end
  end

  always_comb begin
    for (int c = 0; c < 2; c++) begin
      entry4[c] = '0;
      exit4[c]  = tmax;
      for (int a = 0; a < 3; a++) begin
        if (near3[c * 3 + a] > entry4[c]) entry4[c] = near3[c * 3 + a];
        if (far3[c * 3 + a] < exit4[c]) exit4[c] = far3[c * 3 + a];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (vld[2]) begin
      l_entry <= entry4[0];
      r_entry <= entry4[1];
      l_hit   <= entry4[0] <= exit4[0];
      r_hit   <= entry4[1] <= exit4[1];
      l_first <= entry4[0] < entry4[1];  // Ties go right
    end
  end

endmodule

/* traversal_stack.sv */
`timescale 1ns/1ps

module traversal_stack
  import rt_pkg::*;
#(
  parameter int STACK_DEPTH = 16
) (
  input  logic       clk,
  input  logic       counter_reg_reset,
  input  logic       push,
  input  logic       pop,
  input  node_addr_t push_addr,
  output node_addr_t top_addr,
  output logic       empty
);

  localparam int AW = $clog2(STACK_DEPTH);
  localparam int CW = $clog2(STACK_DEPTH + 1);

  node_addr_t    slots [STACK_DEPTH];
  logic [CW-1:0] count;
  logic          full;

  assign empty    = count == '0;
  assign full     = count == CW'(STACK_DEPTH);
  assign top_addr = slots[AW'(count - 1'b1)];  // Last pushed entry

  always_ff @(posedge clk) begin
    if (counter_reg_reset) count <= '0;
    else if (push) count <= count + 1'b1;
    else if (pop) count <= count - 1'b1;
  end

  always_ff @(posedge clk) begin
    if (push) slots[AW'(count)] <= push_addr;
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (counter_reg_reset)
    full |-> !push);
  a_no_underflow: assert property (@(posedge clk) disable iff (counter_reg_reset)
    empty |-> !pop);
  a_one_op: assert property (@(posedge clk) disable iff (counter_reg_reset)
    !(push && pop));

endmodule

/* traversal_ctrl.sv */
`timescale 1ns/1ps

module traversal_ctrl
  import rt_pkg::*;
(
  input  logic        clk,
  input  logic        counter_reg_reset,
  input  logic        ray_valid,
  output logic        fetch_start,
  output node_addr_t  fetch_addr,
  input  logic        pair_valid,
  output logic        slab_start,
  input  logic        slab_valid,
  input  logic        l_hit,
  input  logic        r_hit,
  input  logic        l_first,
  input  coord_t      l_entry,
  input  coord_t      r_entry,
  input  num_trigs_t  l_num_trigs,
  input  num_trigs_t  r_num_trigs,
  input  child_link_u l_link,
  input  child_link_u r_link,
  output logic        push,
  output logic        pop,
  output node_addr_t  push_addr,
  input  node_addr_t  top_addr,
  input  logic        empty,
  output logic        leaf_valid,
  output trig_addr_t  leaf_trig_addr,
  output num_trigs_t  leaf_num_trigs,
  output coord_t      leaf_entry,
  output logic        done
);

  localparam logic [2:0] S_IDLE     = 3'd0;
  localparam logic [2:0] S_FETCH    = 3'd1;
  localparam logic [2:0] S_TEST     = 3'd2;
  localparam logic [2:0] S_REPORT_L = 3'd3;
  localparam logic [2:0] S_REPORT_R = 3'd4;
  localparam logic [2:0] S_STEP     = 3'd5;

  logic [2:0] state;
  logic [2:0] state_next;
  logic       l_go;
  logic       r_go;

  assign l_go = l_hit && (l_num_trigs == '0);  // Hit inner children
  assign r_go = r_hit && (r_num_trigs == '0);

  always_ff @(posedge clk) begin
    if (counter_reg_reset) state <= S_IDLE;
    else state <= state_next;
  end

  always_comb begin
    state_next  = state;
    fetch_start = 1'b0;
    fetch_addr  = '0;   // Root pair
    slab_start  = 1'b0;
    push        = 1'b0;
    pop         = 1'b0;
    push_addr   = '0;
    done        = 1'b0;
    case (state)
      S_IDLE: begin
        if (ray_valid) begin
          fetch_start = 1'b1;
          state_next  = S_FETCH;
        end
      end
      S_FETCH: begin
        if (pair_valid) begin
          slab_start = 1'b1;
          state_next = S_TEST;
        end
      end
      S_TEST: begin
        if (slab_valid) state_next = S_REPORT_L;
      end
      S_REPORT_L: state_next = S_REPORT_R;
      S_REPORT_R: state_next = S_STEP;
      S_STEP: begin
        if (l_go || r_go || !empty) begin
          fetch_start = 1'b1;
          state_next  = S_FETCH;
        end else begin
          done       = 1'b1;
          state_next = S_IDLE;
        end
        if (l_go && r_go) begin
          push       = 1'b1;  // Farther child waits on the stack
          fetch_addr = l_first ? l_link.node.addr : r_link.node.addr;
          push_addr  = l_first ? r_link.node.addr : l_link.node.addr;
        end else if (l_go) begin
          fetch_addr = l_link.node.addr;
        end else if (r_go) begin
          fetch_addr = r_link.node.addr;
        end else begin
          pop        = !empty;
          fetch_addr = top_addr;
        end
      end
      default: state_next = S_IDLE;
    endcase
  end

  // Left leaf goes out one cycle ahead of the right one
  assign leaf_valid = (state == S_REPORT_L && l_hit && l_num_trigs != '0) ||
                      (state == S_REPORT_R && r_hit && r_num_trigs != '0);
  assign leaf_trig_addr = (state == S_REPORT_R) ? r_link.trig : l_link.trig;
  assign leaf_num_trigs = (state == S_REPORT_R) ? r_num_trigs : l_num_trigs;
  assign leaf_entry     = (state == S_REPORT_R) ? r_entry : l_entry;

endmodule

/* rt_traverse.sv */
`timescale 1ns/1ps

module rt_traverse
  import rt_pkg::*;
#(
  parameter int NODE_WORDS  = 4096,
  parameter int STACK_DEPTH = 16
) (
  input  logic        clk,
  input  logic        counter_reg_reset,
  input  logic        mem_we,
  input  node_addr_t  mem_addr,
  input  logic [31:0] mem_wdata,
  input  logic        ray_valid,
  input  coord_t      origin_x,
  input  coord_t      origin_y,
  input  coord_t      origin_z,
  input  coord_t      inv_dir_x,
  input  coord_t      inv_dir_y,
  input  coord_t      inv_dir_z,
  input  coord_t      tmax,
  output logic        leaf_valid,
  output trig_addr_t  leaf_trig_addr,
  output num_trigs_t  leaf_num_trigs,
  output coord_t      leaf_entry,
  output logic        done
);

  logic        fetch_start, pair_valid, slab_start, slab_valid;
  logic        l_hit, r_hit, l_first;
  logic        push, pop, empty;
  node_addr_t  fetch_addr, mem_rd_addr, push_addr, top_addr;
  logic [31:0] mem_rdata;
  coord_t      l_bounds [6];
  coord_t      r_bounds [6];
  coord_t      l_entry, r_entry;
  num_trigs_t  l_num_trigs, r_num_trigs;
  child_link_u l_link, r_link;

  node_memory #(.NODE_WORDS(NODE_WORDS)) u_node_memory (
    .clk(clk), .mem_we(mem_we), .mem_wr_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_rd_addr(mem_rd_addr), .mem_rdata(mem_rdata)
  );

  node_fetch u_node_fetch (
    .clk(clk), .counter_reg_reset(counter_reg_reset),
    .fetch_start(fetch_start), .fetch_addr(fetch_addr),
    .mem_rd_addr(mem_rd_addr), .mem_rdata(mem_rdata), .pair_valid(pair_valid),
    .l_bounds(l_bounds), .r_bounds(r_bounds),
    .l_num_trigs(l_num_trigs), .r_num_trigs(r_num_trigs),
    .l_link(l_link), .r_link(r_link)
  );

  slab_test u_slab_test (
    .clk(clk), .counter_reg_reset(counter_reg_reset), .slab_start(slab_start),
    .origin_x(origin_x), .origin_y(origin_y), .origin_z(origin_z),
    .inv_dir_x(inv_dir_x), .inv_dir_y(inv_dir_y), .inv_dir_z(inv_dir_z),
    .tmax(tmax), .l_bounds(l_bounds), .r_bounds(r_bounds),
    .slab_valid(slab_valid), .l_hit(l_hit), .r_hit(r_hit), .l_first(l_first),
    .l_entry(l_entry), .r_entry(r_entry)
  );

  traversal_stack #(.STACK_DEPTH(STACK_DEPTH)) u_traversal_stack (
    .clk(clk), .counter_reg_reset(counter_reg_reset), .push(push), .pop(pop),
    .push_addr(push_addr), .top_addr(top_addr), .empty(empty)
  );

  traversal_ctrl u_traversal_ctrl (
    .clk(clk), .counter_reg_reset(counter_reg_reset), .ray_valid(ray_valid),
    .fetch_start(fetch_start), .fetch_addr(fetch_addr), .pair_valid(pair_valid),
    .slab_start(slab_start), .slab_valid(slab_valid),
    .l_hit(l_hit), .r_hit(r_hit), .l_first(l_first),
    .l_entry(l_entry), .r_entry(r_entry),
    .l_num_trigs(l_num_trigs), .r_num_trigs(r_num_trigs),
    .l_link(l_link), .r_link(r_link),
    .push(push), .pop(pop), .push_addr(push_addr), .top_addr(top_addr), .empty(empty),
    .leaf_valid(leaf_valid), .leaf_trig_addr(leaf_trig_addr),
    .leaf_num_trigs(leaf_num_trigs), .leaf_entry(leaf_entry), .done(done)
  );

endmodule

/* tb_rt_traverse.sv */
`timescale 1ns/1ps

module tb_rt_traverse
  import rt_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int MAX_PAIRS = 12;
  localparam int RAND_RAYS = 200;
  localparam int PAIR_CYCLES = 17 + SLAB_LATENCY + 4;  // Fetch, slab test, report and step
  localparam int RAY_BUDGET = MAX_PAIRS * (PAIR_CYCLES + WORDS_PER_PAIR) + 40;
  localparam int RUN_CYCLES = (RAND_RAYS + 8) * RAY_BUDGET;

  logic        clk = 1'b0;
  logic        counter_reg_reset;
  logic        mem_we;
  node_addr_t  mem_addr;
  logic [31:0] mem_wdata;
  logic        ray_valid;
  coord_t      origin_x, origin_y, origin_z;
  coord_t      inv_dir_x, inv_dir_y, inv_dir_z;
  coord_t      tmax;
  logic        leaf_valid;
  trig_addr_t  leaf_trig_addr;
  num_trigs_t  leaf_num_trigs;
  coord_t      leaf_entry;
  logic        done;

  // Tree image with box words in W_* order
  coord_t     box [MAX_PAIRS][2][6];
  num_trigs_t cnt [MAX_PAIRS][2];
  int         kid [MAX_PAIRS][2];
  trig_addr_t trig [MAX_PAIRS][2];
  int         n_pairs;

  coord_t     ray_org [3];
  coord_t     ray_inv [3];
  coord_t     ray_tmax;
  trig_addr_t exp_trig [$];
  num_trigs_t exp_cnt [$];
  coord_t     exp_entry [$];
  int         exp_pairs;

  int   errors = 0;
  int   leaves_checked = 0;
  int   rays_run = 0;
  logic hung = 1'b0;

  rt_traverse #(.NODE_WORDS(4096), .STACK_DEPTH(16)) dut0 (
    .clk(clk), .counter_reg_reset(counter_reg_reset),
    .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .ray_valid(ray_valid), .origin_x(origin_x), .origin_y(origin_y), .origin_z(origin_z),
    .inv_dir_x(inv_dir_x), .inv_dir_y(inv_dir_y), .inv_dir_z(inv_dir_z), .tmax(tmax),
    .leaf_valid(leaf_valid), .leaf_trig_addr(leaf_trig_addr),
    .leaf_num_trigs(leaf_num_trigs), .leaf_entry(leaf_entry), .done(done)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic coord_t rand_in(input int lo, input int hi);
    return coord_t'(lo + int'($urandom_range(hi - lo, 0)));
  endfunction

  function automatic coord_t scaled_dist(input coord_t delta, input coord_t inv);
    longint prod;
    prod = longint'(delta) * longint'(inv);
    return coord_t'(prod >>> FRAC_BITS);
  endfunction

  function automatic void test_box(input int p, input int c, output logic hit,
                                   output coord_t entry);
    coord_t ex;
    coord_t lo;
    coord_t hi;
    entry = '0;
    ex = ray_tmax;
    for (int a = 0; a < 3; a++) begin
      lo = scaled_dist(box[p][c][2 * a] - ray_org[a], ray_inv[a]);
      hi = scaled_dist(box[p][c][2 * a + 1] - ray_org[a], ray_inv[a]);
      if (ray_inv[a] < 0) begin  // Slab is entered through its max plane
        entry = (hi > entry) ? hi : entry;
        ex = (lo < ex) ? lo : ex;
      end else begin
        entry = (lo > entry) ? lo : entry;
        ex = (hi < ex) ? hi : ex;
      end
    end
    hit = entry <= ex;
  endfunction

  // Reference walk of the tree image with deferred pairs kept in a LIFO
  function automatic void build_expected();
    int     stack_q [$];
    int     p;
    logic   more;
    logic   hit [2];
    coord_t ent [2];
    logic   go [2];
    exp_trig.delete();
    exp_cnt.delete();
    exp_entry.delete();
    exp_pairs = 0;
    p = 0;
    more = 1'b1;
    while (more) begin
      exp_pairs++;
      for (int c = 0; c < 2; c++) begin
        test_box(p, c, hit[c], ent[c]);
        go[c] = hit[c] && cnt[p][c] == '0;
        if (hit[c] && cnt[p][c] != '0) begin
          exp_trig.push_back(trig[p][c]);
          exp_cnt.push_back(cnt[p][c]);
          exp_entry.push_back(ent[c]);
        end
      end
      if (go[0] && go[1]) begin
        stack_q.push_back(ent[0] < ent[1] ? kid[p][1] : kid[p][0]);
        p = ent[0] < ent[1] ? kid[p][0] : kid[p][1];
      end else if (go[0]) p = kid[p][0];
      else if (go[1]) p = kid[p][1];
      else if (stack_q.size() != 0) p = stack_q.pop_back();
      else more = 1'b0;
    end
  endfunction

  // Box spans y and z widely so only x decides a hit
  function automatic void set_child(input int p, input int c, input int xlo, input int xhi,
                                    input int n, input int link);
    box[p][c][W_X_MIN] = xlo;
    box[p][c][W_X_MAX] = xhi;
    box[p][c][W_Y_MIN] = -1000;
    box[p][c][W_Y_MAX] = 1000;
    box[p][c][W_Z_MIN] = -1000;
    box[p][c][W_Z_MAX] = 1000;
    cnt[p][c] = 8'(n);
    kid[p][c] = link;
    trig[p][c] = 14'(link);
  endfunction

  // Pairs are numbered breadth first, so inner links always point further down
  function automatic void make_random_tree();
    int target;
    target = int'($urandom_range(MAX_PAIRS, 1));
    n_pairs = 1;
    for (int p = 0; p < n_pairs; p++) begin
      for (int c = 0; c < 2; c++) begin
        for (int a = 0; a < 3; a++) begin
          box[p][c][2 * a] = rand_in(-1024, 800);
          box[p][c][2 * a + 1] = rand_in(box[p][c][2 * a], 1023);
        end
        if (n_pairs < target && $urandom_range(1, 0) == 1) begin
          cnt[p][c] = '0;
          kid[p][c] = n_pairs;
          n_pairs++;
        end else begin
          cnt[p][c] = 8'($urandom_range(255, 1));
          trig[p][c] = 14'($urandom_range(16383, 0));
        end
      end
    end
  endfunction

  task automatic load_tree();
    for (int p = 0; p < n_pairs; p++) begin
      for (int w = 0; w < WORDS_PER_PAIR; w++) begin
        int c;
        int off;
        c = w / WORDS_PER_CHILD;
        off = w % WORDS_PER_CHILD;
        @(posedge clk);
        mem_we <= 1'b1;
        mem_addr <= node_addr_t'(p * WORDS_PER_PAIR + w);
        if (off == W_NUM_TRIGS) mem_wdata <= {24'd0, cnt[p][c]};
        else if (off == W_LINK) mem_wdata <= (cnt[p][c] == '0) ?
            32'(kid[p][c] * WORDS_PER_PAIR) : {18'd0, trig[p][c]};
        else mem_wdata <= box[p][c][off];
      end
    end
    @(posedge clk);
    mem_we <= 1'b0;
  endtask

  function automatic void check_leaf(input int i);
    leaves_checked++;
    assert (leaf_trig_addr == exp_trig[i]) else begin
      errors++;
      $display("ERR %0t leaf_trig_addr got %h exp %h", $time, leaf_trig_addr, exp_trig[i]);
    end
    assert (leaf_num_trigs == exp_cnt[i]) else begin
      errors++;
      $display("ERR %0t leaf_num_trigs got %0d exp %0d", $time, leaf_num_trigs, exp_cnt[i]);
    end
    assert (leaf_entry == exp_entry[i]) else begin
      errors++;
      $display("ERR %0t leaf_entry got %0d exp %0d", $time, leaf_entry, exp_entry[i]);
    end
  endfunction

  task automatic run_ray(input coord_t ox, oy, oz, ix, iy, iz, tm);
    int   got;
    int   limit;
    int   cycles;
    logic seen_done;
    ray_org[0] = ox;
    ray_org[1] = oy;
    ray_org[2] = oz;
    ray_inv[0] = ix;
    ray_inv[1] = iy;
    ray_inv[2] = iz;
    ray_tmax = tm;
    build_expected();
    limit = exp_pairs * PAIR_CYCLES + 20;
    @(posedge clk);
    ray_valid <= 1'b1;
    origin_x <= ox;
    origin_y <= oy;
    origin_z <= oz;
    inv_dir_x <= ix;
    inv_dir_y <= iy;
    inv_dir_z <= iz;
    tmax <= tm;
    @(posedge clk);
    ray_valid <= 1'b0;
    got = 0;
    cycles = 0;
    seen_done = 1'b0;
    while (!seen_done && cycles < limit) begin
      @(negedge clk);
      cycles++;
      if (leaf_valid) begin
        assert (got < exp_trig.size()) else begin
          errors++;
          $display("Extra leaf strobe at %0t, only %0d leaves expected", $time, exp_trig.size());
        end
        if (got < exp_trig.size()) check_leaf(got);
        got++;
      end
      seen_done = done;
    end
    rays_run++;
    assert (seen_done) else begin
      errors++;
      hung = 1'b1;
      $display("Ray %0d got no done within %0d cycles", rays_run, limit);
    end
    assert (got >= exp_trig.size()) else begin
      errors++;
      $display("Ray %0d ended after %0d of %0d leaves", rays_run, got, exp_trig.size());
    end
  endtask

  initial begin
    void'($urandom(32'hef3d));
    counter_reg_reset = 1'b1;
    mem_we = 1'b0;
    mem_addr = '0;
    mem_wdata = '0;
    ray_valid = 1'b0;
    origin_x = '0;
    origin_y = '0;
    origin_z = '0;
    inv_dir_x = '0;
    inv_dir_y = '0;
    inv_dir_z = '0;
    tmax = '0;
    repeat (4) @(posedge clk);
    counter_reg_reset <= 1'b0;
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      assert (leaf_valid == 1'b0) else begin
        errors++;
        $display("ERR %0t leaf_valid got %b exp 0", $time, leaf_valid);
      end
      assert (done == 1'b0) else begin
        errors++;
        $display("ERR %0t done got %b exp 0", $time, done);
      end
    end
    n_pairs = 1;
    set_child(0, 0, 100, 200, 3, 'h0123);
    set_child(0, 1, 300, 400, 5, 'h2345);
    load_tree();
    run_ray(0, 0, 0, 65536, 65536, 65536, 50);  // Short of both boxes
    run_ray(0, 0, 0, 65536, 65536, 65536, 1000);
    // Pair 2 is nearer than pair 1, so pair 1 waits on the stack
    n_pairs = 4;
    set_child(0, 0, 300, 400, 0, 1);
    set_child(0, 1, 100, 200, 0, 2);
    set_child(1, 0, 310, 320, 2, 100);
    set_child(1, 1, 350, 360, 4, 101);
    set_child(2, 0, 120, 150, 0, 3);
    set_child(2, 1, 160, 180, 1, 102);
    set_child(3, 0, 125, 130, 6, 103);
    set_child(3, 1, 140, 145, 7, 104);
    load_tree();
    run_ray(0, 0, 0, 65536, 65536, 65536, 1000);
    run_ray(0, 0, 0, 65536, 65536, 65536, 150);
    for (int i = 0; i < RAND_RAYS && !hung; i++) begin
      make_random_tree();
      load_tree();
      run_ray(rand_in(-512, 511), rand_in(-512, 511), rand_in(-512, 511),
              rand_in(-262144, 262144), rand_in(-262144, 262144), rand_in(-262144, 262144),
              rand_in(0, 4000));
    end
    $display("Rays run %0d, leaves checked %0d, errors %0d", rays_run, leaves_checked, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles", RUN_CYCLES);
    $display("Rays run %0d, leaves checked %0d, errors %0d", rays_run, leaves_checked, errors);
    $display("Test failures found");
    $finish;
  end

endmodule

/* filelist.f */
rt_pkg.sv
node_memory.sv
node_fetch.sv
slab_test.sv
traversal_stack.sv
traversal_ctrl.sv
rt_traverse.sv
tb_rt_traverse.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the traversal testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_rt_traverse -o sim_rt_traverse
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_rt_traverse)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'All tests passed!'; then
  exit 0
fi
exit 1
